// File: src/rv32_consts.svh
/*
 * RV32 pipeline constants
 * Widths, reset address and the RV32I opcode and funct3 encodings
 */
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

// Datapath and register index widths
`define XLEN     32
`define REG_AW   5
`define NUM_REGS 32
`define RESET_PC 32'h0000_0000

// Major opcodes, bits 6:0 of the instruction
`define OPC_LUI    7'b0110111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011

// funct3 for ALU operations, shared by OP and OP-IMM
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111
// funct3 for memory and branch groups
`define F3_LB      3'b000
`define F3_LW      3'b010
`define F3_LBU     3'b100
`define F3_SB      3'b000
`define F3_SW      3'b010
`define F3_BEQ     3'b000
`define F3_BNE     3'b001
`define F3_BLT     3'b100
`define F3_BGE     3'b101

`endif

// File: src/rv32_pkg.sv
/*
 * RV32 pipeline types
 * Operation encoding and the packed records passed between stages
 */
`include "rv32_consts.svh"

package rv32_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Decoded operations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
        OP_LUI,
        OP_LW, OP_LB, OP_LBU,
        OP_SW, OP_SB,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
        OP_JAL, OP_JALR,
        OP_NOP
    } iType_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////////////////////

    // Fetched word and its address
    typedef struct packed {
        logic                valid;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    instr;
    } fetch_to_decode_t;

    // Operands already resolved, forwarding included
    typedef struct packed {
        logic                valid;
        iType_e              op;
        logic [`XLEN-1:0]    pc;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    op1;
        // rs2 data or immediate
        logic [`XLEN-1:0]    op2;
        logic [`XLEN-1:0]    store_data;
        // pc plus B or J immediate
        logic [`XLEN-1:0]    jump_imm_target;
    } decode_to_exec_t;

    typedef struct packed {
        logic                valid;
        iType_e              op;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    result;
        // Low address bits, byte select for LB and LBU
        logic [1:0]          byte_offset;
    } exec_to_retire_t;

    typedef struct packed {
        logic                we;
        logic [`REG_AW-1:0]  rd;
        logic [`XLEN-1:0]    data;
    } writeback_t;

endpackage

// File: src/fetch.sv
/*
 * Fetch stage
 * Program counter, instruction capture and redirect on taken jumps
 */
`include "rv32_consts.svh"

module fetch
    import rv32_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stall_i,
    input  logic              hazard_i,
    input  logic              jump_i,
    input  logic [`XLEN-1:0]  jump_target_i,
    input  logic [`XLEN-1:0]  instruction_i,
    output logic [`XLEN-1:0]  instruction_address_o,
    output fetch_to_decode_t  to_decode_o
);

    logic [`XLEN-1:0] pc;

    // Memory answers in the same cycle
    assign instruction_address_o = pc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc <= `RESET_PC;
        end
        else if (!stall_i) begin
            // Redirect wins over the load-use hold
            if (jump_i) begin
                pc <= jump_target_i;
            end
            else if (!hazard_i) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            to_decode_o.valid <= 1'b0;
        end
        else if (!stall_i) begin
            if (jump_i) begin
                // Word at the old pc is on the wrong path
                to_decode_o.valid <= 1'b0;
            end
            else if (!hazard_i) begin
                to_decode_o <= '{valid: 1'b1, pc: pc, instr: instruction_i};
            end
        end
    end

endmodule

// File: src/decode.sv
/*
 * Decode stage
 * Operation and immediate decoding, operand forwarding, load-use hazard
 */
`include "rv32_consts.svh"

module decode
    import rv32_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  logic               jump_i,
    input  fetch_to_decode_t   from_fetch_i,
    output logic [`REG_AW-1:0] rs1_o,
    output logic [`REG_AW-1:0] rs2_o,
    input  logic [`XLEN-1:0]   rs1_data_i,
    input  logic [`XLEN-1:0]   rs2_data_i,
    input  logic [`REG_AW-1:0] exec_rd_i,
    input  logic [`XLEN-1:0]   exec_result_i,
    input  logic               exec_fwd_valid_i,
    input  logic               exec_is_load_i,
    input  writeback_t         writeback_i,
    output logic               hazard_o,
    output decode_to_exec_t    to_exec_o
);

    logic [`XLEN-1:0] instr;
    logic [6:0]       opcode;
    logic [2:0]       f3;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`XLEN-1:0] rs1_val, rs2_val;
    decode_to_exec_t  next;

    assign instr  = from_fetch_i.instr;
    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////////////////////

    // Youngest producer first: execute, then retire, then the bank
    function automatic logic [`XLEN-1:0] fwd(input logic [`REG_AW-1:0] rs,
                                              input logic [`XLEN-1:0]   bank);
        if (rs != '0 && exec_fwd_valid_i && exec_rd_i == rs)
            return exec_result_i;
        if (rs != '0 && writeback_i.we && writeback_i.rd == rs)
            return writeback_i.data;
        return bank;
    endfunction

    always_comb begin
        rs1_val = fwd(rs1_o, rs1_data_i);
        rs2_val = fwd(rs2_o, rs2_data_i);
    end

    // Load result only exists one stage later, so wait a cycle
    assign hazard_o = from_fetch_i.valid && exec_is_load_i && exec_rd_i != '0
                   && (exec_rd_i == rs1_o || exec_rd_i == rs2_o);

    ////////////////////////////////////////////////////////////////////////////
    // Operation decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next.valid           = from_fetch_i.valid && !hazard_o && !jump_i;
        next.op              = OP_NOP;
        next.pc              = from_fetch_i.pc;
        next.rd              = instr[11:7];
        next.op1             = rs1_val;
        next.op2             = imm_i;
        next.store_data      = rs2_val;
        next.jump_imm_target = from_fetch_i.pc + imm_b;
        case (opcode)
            `OPC_OP: begin
                next.op2 = rs2_val;
                case (f3)
                    `F3_ADD_SUB: next.op = instr[30] ? OP_SUB : OP_ADD;
                    `F3_SLL:     next.op = OP_SLL;
                    `F3_SLT:     next.op = OP_SLT;
                    `F3_SLTU:    next.op = OP_SLTU;
                    `F3_XOR:     next.op = OP_XOR;
                    `F3_SRL_SRA: next.op = instr[30] ? OP_SRA : OP_SRL;
                    `F3_OR:      next.op = OP_OR;
                    default:     next.op = OP_AND;
                endcase
            end
            `OPC_OPIMM: begin
                case (f3)
                    `F3_ADD_SUB: next.op = OP_ADD;
                    `F3_SLL:     next.op = OP_SLL;
                    `F3_SLT:     next.op = OP_SLT;
                    `F3_XOR:     next.op = OP_XOR;
                    `F3_SRL_SRA: next.op = instr[30] ? OP_SRA : OP_SRL;
                    `F3_OR:      next.op = OP_OR;
                    `F3_AND:     next.op = OP_AND;
                    // SLTIU is not supported
                    default:     next.op = OP_NOP;
                endcase
            end
            `OPC_LUI: begin
                next.op  = OP_LUI;
                next.op2 = imm_u;
            end
            `OPC_JAL: begin
                next.op              = OP_JAL;
                next.jump_imm_target = from_fetch_i.pc + imm_j;
            end
            `OPC_JALR: next.op = OP_JALR;
            `OPC_BRANCH: begin
                next.op2 = rs2_val;
                case (f3)
                    `F3_BEQ: next.op = OP_BEQ;
                    `F3_BNE: next.op = OP_BNE;
                    `F3_BLT: next.op = OP_BLT;
                    `F3_BGE: next.op = OP_BGE;
                    default: next.op = OP_NOP;
                endcase
            end
            `OPC_LOAD: begin
                case (f3)
                    `F3_LB:  next.op = OP_LB;
                    `F3_LW:  next.op = OP_LW;
                    `F3_LBU: next.op = OP_LBU;
                    default: next.op = OP_NOP;
                endcase
            end
            `OPC_STORE: begin
                next.op2 = imm_s;
                case (f3)
                    `F3_SB:  next.op = OP_SB;
                    `F3_SW:  next.op = OP_SW;
                    default: next.op = OP_NOP;
                endcase
            end
            default: next.op = OP_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            to_exec_o.valid <= 1'b0;
        end
        else if (!stall_i) begin
            to_exec_o <= next;
        end
    end

endmodule

// File: src/regbank.sv
/*
 * Register bank
 * 32 x 32 flip-flop file, two combinational reads, x0 fixed at zero
 */
`include "rv32_consts.svh"

module regbank
    import rv32_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic [`REG_AW-1:0] rs1_i,
    input  logic [`REG_AW-1:0] rs2_i,
    input  writeback_t         writeback_i,
    output logic [`XLEN-1:0]   rs1_data_o,
    output logic [`XLEN-1:0]   rs2_data_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs <= '{default: '0};
        end
        else if (writeback_i.we && writeback_i.rd != '0) begin
            regs[writeback_i.rd] <= writeback_i.data;
        end
    end

    // x0 never written, so it keeps its reset value
    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

// File: src/execute.sv
/*
 * Execute stage
 * ALU, branch and jump resolution, data memory request, retire register
 */
`include "rv32_consts.svh"

module execute
    import rv32_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  decode_to_exec_t    from_decode_i,
    output logic               jump_o,
    output logic [`XLEN-1:0]   jump_target_o,
    output logic [`REG_AW-1:0] fwd_rd_o,
    output logic [`XLEN-1:0]   fwd_result_o,
    output logic               fwd_valid_o,
    output logic               fwd_is_load_o,
    output logic               mem_operation_enable_o,
    output logic [3:0]         mem_write_enable_o,
    output logic [`XLEN-1:0]   mem_address_o,
    output logic [`XLEN-1:0]   mem_data_o,
    output exec_to_retire_t    to_retire_o
);

    logic [`XLEN-1:0] op1, op2;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] result;
    logic             taken;
    logic             is_load, is_store;

    assign op1 = from_decode_i.op1;
    assign op2 = from_decode_i.op2;
    // One adder for ADD, memory address and JALR target
    assign sum = op1 + op2;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (from_decode_i.op)
            OP_SUB:  result = op1 - op2;
            OP_AND:  result = op1 & op2;
            OP_OR:   result = op1 | op2;
            OP_XOR:  result = op1 ^ op2;
            OP_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
            OP_SLTU: result = {31'b0, op1 < op2};
            OP_SLL:  result = op1 << op2[4:0];
            OP_SRL:  result = op1 >> op2[4:0];
            OP_SRA:  result = $unsigned($signed(op1) >>> op2[4:0]);
            OP_LUI:  result = op2;
            // Link value
            OP_JAL, OP_JALR: result = from_decode_i.pc + 32'd4;
            default: result = sum;
        endcase
    end

    // Branch compare
    always_comb begin
        case (from_decode_i.op)
            OP_BEQ:  taken = op1 == op2;
            OP_BNE:  taken = op1 != op2;
            OP_BLT:  taken = $signed(op1) < $signed(op2);
            OP_BGE:  taken = $signed(op1) >= $signed(op2);
            OP_JAL, OP_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump_o        = from_decode_i.valid && taken;
    assign jump_target_o = (from_decode_i.op == OP_JALR) ? {sum[`XLEN-1:1], 1'b0}
                                                         : from_decode_i.jump_imm_target;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding and memory request
    ////////////////////////////////////////////////////////////////////////////

    assign is_load  = from_decode_i.op inside {OP_LW, OP_LB, OP_LBU};
    assign is_store = from_decode_i.op inside {OP_SW, OP_SB};

    assign fwd_rd_o      = from_decode_i.rd;
    assign fwd_result_o  = result;
    assign fwd_is_load_o = from_decode_i.valid && is_load;
    assign fwd_valid_o   = from_decode_i.valid && !is_load && !is_store
                        && !(from_decode_i.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_NOP});

    // Held back while stalled, issued once the stall drops
    assign mem_operation_enable_o = from_decode_i.valid && (is_load || is_store) && !stall_i;
    assign mem_address_o          = {sum[`XLEN-1:2], 2'b00};

    always_comb begin
        mem_write_enable_o = 4'b0000;
        mem_data_o         = from_decode_i.store_data;
        if (mem_operation_enable_o && from_decode_i.op == OP_SW) begin
            mem_write_enable_o = 4'b1111;
        end
        else if (mem_operation_enable_o && from_decode_i.op == OP_SB) begin
            // Byte on every lane, lane picked by the address
            mem_write_enable_o = 4'b0001 << sum[1:0];
            mem_data_o         = {4{from_decode_i.store_data[7:0]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            to_retire_o.valid <= 1'b0;
        end
        else if (!stall_i) begin
            to_retire_o.valid       <= from_decode_i.valid;
            to_retire_o.op          <= from_decode_i.op;
            to_retire_o.rd          <= from_decode_i.rd;
            to_retire_o.result      <= result;
            to_retire_o.byte_offset <= sum[1:0];
        end
    end

endmodule

// File: src/retire.sv
/*
 * Retire stage
 * Load data extraction and register writeback
 */
`include "rv32_consts.svh"

module retire
    import rv32_pkg::*;
(
    input  exec_to_retire_t   from_exec_i,
    input  logic              stall_i,
    input  logic [`XLEN-1:0]  mem_data_i,
    output writeback_t        writeback_o
);

    logic [7:0] load_byte;

    // Byte lane chosen by the low address bits
    assign load_byte = mem_data_i[from_exec_i.byte_offset*8 +: 8];

    always_comb begin
        case (from_exec_i.op)
            OP_LW:   writeback_o.data = mem_data_i;
            OP_LB:   writeback_o.data = {{24{load_byte[7]}}, load_byte};
            OP_LBU:  writeback_o.data = {24'b0, load_byte};
            default: writeback_o.data = from_exec_i.result;
        endcase
    end

    assign writeback_o.rd = from_exec_i.rd;
    // Stores, branches and NOPs leave the bank alone
    assign writeback_o.we = from_exec_i.valid && !stall_i
        && !(from_exec_i.op inside {OP_SW, OP_SB, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_NOP});

endmodule

// File: src/rv32_pipe.sv
/*
 * rv32_pipe top level
 * Four-stage in-order RV32I core with separate instruction and data ports
 */
`include "rv32_consts.svh"

module rv32_pipe
    import rv32_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              stall_i,
    input  logic [`XLEN-1:0]  instruction_i,
    input  logic [`XLEN-1:0]  mem_data_i,
    output logic [`XLEN-1:0]  instruction_address_o,
    output logic              mem_operation_enable_o,
    output logic [3:0]        mem_write_enable_o,
    output logic [`XLEN-1:0]  mem_address_o,
    output logic [`XLEN-1:0]  mem_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage records and control
    ////////////////////////////////////////////////////////////////////////////

    fetch_to_decode_t   if_id;
    decode_to_exec_t    id_ex;
    exec_to_retire_t    ex_rt;
    writeback_t         wb;

    logic               jump, hazard;
    logic [`XLEN-1:0]   jump_target;
    logic [`REG_AW-1:0] rs1, rs2, fwd_rd;
    logic [`XLEN-1:0]   rs1_data, rs2_data, fwd_result;
    logic               fwd_valid, fwd_is_load;

    fetch u_fetch (
        .clk                   (clk),
        .reset_i               (reset_i),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .to_decode_o           (if_id)
    );

    decode u_decode (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .jump_i           (jump),
        .from_fetch_i     (if_id),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .exec_rd_i        (fwd_rd),
        .exec_result_i    (fwd_result),
        .exec_fwd_valid_i (fwd_valid),
        .exec_is_load_i   (fwd_is_load),
        .writeback_i      (wb),
        .hazard_o         (hazard),
        .to_exec_o        (id_ex)
    );

    regbank u_regbank (
        .clk         (clk),
        .reset_i     (reset_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .writeback_i (wb),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data)
    );

    // Memory request goes straight to the ports
    execute u_execute (
        .clk                    (clk),
        .reset_i                (reset_i),
        .stall_i                (stall_i),
        .from_decode_i          (id_ex),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .fwd_rd_o               (fwd_rd),
        .fwd_result_o           (fwd_result),
        .fwd_valid_o            (fwd_valid),
        .fwd_is_load_o          (fwd_is_load),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .to_retire_o            (ex_rt)
    );

    retire u_retire (
        .from_exec_i (ex_rt),
        .stall_i     (stall_i),
        .mem_data_i  (mem_data_i),
        .writeback_o (wb)
    );

endmodule

// File: tests/tb_program.svh
/*
 * Program builder for the rv32_pipe testbench
 * RV32I encoders and random ALU, load/store and branch blocks with expected stores
 */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Instruction formats
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [2:0] f3);
    // Base is always x0, addresses fit in 12 bits
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], `OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
endfunction

// ALU index: 0 ADD, 1 SUB, 2 AND, 3 OR, 4 XOR, 5 SLT, 6 SLTU, 7 SLL, 8 SRL, 9 SRA
function automatic logic [2:0] alu_f3(input int k);
    case (k)
        0, 1:    return `F3_ADD_SUB;
        2:       return `F3_AND;
        3:       return `F3_OR;
        4:       return `F3_XOR;
        5:       return `F3_SLT;
        6:       return `F3_SLTU;
        7:       return `F3_SLL;
        default: return `F3_SRL_SRA;
    endcase
endfunction

function automatic logic [6:0] alu_f7(input int k);
    return (k == 1 || k == 9) ? 7'b0100000 : 7'b0000000;
endfunction

// RV32I result rules
function automatic logic [31:0] alu_ref(input int k, input logic [31:0] a,
        input logic [31:0] b);
    case (k)
        0:       return a + b;
        1:       return a - b;
        2:       return a & b;
        3:       return a | b;
        4:       return a ^ b;
        // Signs differ, so the negative one is smaller
        5:       return ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
        6:       return (a < b) ? 32'd1 : 32'd0;
        7:       return a << b[4:0];
        8:       return a >> b[4:0];
        // Logical shift with the vacated top bits filled by the sign
        default: return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0]));
    endcase
endfunction

// Immediate forms have no SUB and no SLTIU
function automatic int pick_imm_op(input int idx);
    case (idx)
        0:       return 0;
        1:       return 2;
        2:       return 3;
        3:       return 4;
        4:       return 5;
        5:       return 7;
        6:       return 8;
        default: return 9;
    endcase
endfunction

task automatic emit(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len++;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [3:0] we,
        input logic [31:0] data);
    expected_q.push_back(mem_write_t'{addr: addr, we: we, data: data});
endtask

// LUI plus ADDI, upper part rounded for the sign of the low 12 bits
task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit({hi[19:0], rd, `OPC_LUI});
    emit(i_type(v[11:0], rd, `F3_ADD_SUB, rd, `OPC_OPIMM));
endtask

task automatic store_result(input logic [4:0] rs, input logic [31:0] value);
    emit(s_type(res_addr[11:0], rs, `F3_SW));
    expect_store(res_addr, 4'b1111, value);
    res_addr += 4;
endtask

////////////////////////////////////////////////////////////////////////////
// Blocks
////////////////////////////////////////////////////////////////////////////

// Back-to-back dependent operands exercise both forwarding paths
task automatic alu_block();
    logic [31:0] a, b;
    logic [11:0] imm;
    int          k;
    a = $random(seed);
    b = $random(seed);
    load_const(5'd1, a);
    if ($unsigned($random(seed)) % 2 == 0) begin
        k = $unsigned($random(seed)) % 10;
        load_const(5'd2, b);
        emit(r_type(alu_f7(k), 5'd2, 5'd1, alu_f3(k), 5'd3));
    end
    else begin
        k   = pick_imm_op($unsigned($random(seed)) % 8);
        imm = b[11:0];
        // Shift immediates carry funct7 in the top bits
        if (k >= 7)
            imm = {alu_f7(k), b[4:0]};
        b = {{20{imm[11]}}, imm};
        emit(i_type(imm, 5'd1, alu_f3(k), 5'd3, `OPC_OPIMM));
    end
    store_result(5'd3, alu_ref(k, a, b));
endtask

task automatic load_block();
    logic [31:0] v, d;
    logic [7:0]  byte_v;
    int          lane;
    v    = $random(seed);
    d    = LOAD_BASE + 4 * load_idx;
    lane = $unsigned($random(seed)) % 4;
    load_idx++;
    byte_v = v[8*lane +: 8];
    load_const(5'd1, v);
    emit(s_type(d[11:0], 5'd1, `F3_SW));
    expect_store(d, 4'b1111, v);
    emit(i_type(d[11:0] + lane[11:0], 5'd0, `F3_LB, 5'd4, `OPC_LOAD));
    emit(i_type(d[11:0] + lane[11:0], 5'd0, `F3_LBU, 5'd5, `OPC_LOAD));
    emit(i_type(d[11:0], 5'd0, `F3_LW, 5'd6, `OPC_LOAD));
    // Store right after LW hits the load-use bubble
    store_result(5'd6, v);
    store_result(5'd4, {{24{byte_v[7]}}, byte_v});
    store_result(5'd5, {24'b0, byte_v});
    emit(s_type(d[11:0] + lane[11:0], 5'd1, `F3_SB));
    expect_store(d, 4'b0001 << lane, {4{v[7:0]}});
endtask

// Taken branch and JAL, each skipping a store to the forbidden word
task automatic branch_block();
    logic [31:0] v1, v2, jal_addr;
    int          sel;
    v1  = $random(seed);
    v2  = $random(seed);
    sel = $unsigned($random(seed)) % 3;
    if (v2 == v1)
        v2 = v1 ^ 32'd1;
    load_const(5'd1, v1);
    load_const(5'd2, v2);
    if (sel == 0)
        emit(b_type(13'd8, 5'd2, 5'd1, `F3_BNE));
    else if (sel == 1)
        emit(b_type(13'd8, 5'd1, 5'd1, `F3_BEQ));
    else if ($signed(v1) < $signed(v2))
        emit(b_type(13'd8, 5'd2, 5'd1, `F3_BLT));
    else
        emit(b_type(13'd8, 5'd2, 5'd1, `F3_BGE));
    emit(s_type(FORBID_ADDR[11:0], 5'd1, `F3_SW));
    jal_addr = prog_len * 4;
    emit(j_type(21'd8, 5'd7));
    emit(s_type(FORBID_ADDR[11:0], 5'd1, `F3_SW));
    store_result(5'd7, jal_addr + 32'd4);
endtask

task automatic build_program();
    int kind;
    for (int i = 0; i < ROM_WORDS; i++)
        rom[i] = NOP_WORD;
    prog_len = 0;
    load_idx = 0;
    res_addr = RESULT_BASE;
    for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
        kind = $unsigned($random(seed)) % 3;
        if (kind == 0)
            alu_block();
        else if (kind == 1)
            load_block();
        else
            branch_block();
    end
    // Park the core on a self loop
    emit(j_type(21'd0, 5'd0));
endtask

`endif

// File: tests/tb_rv32_pipe.sv
/*
 * Testbench for rv32_pipe
 * Instruction ROM, byte-enabled data RAM, random stalls and store checking
 */
`include "rv32_consts.svh"

module tb_rv32_pipe;

    localparam int          NUM_BLOCKS  = 40;
    localparam int          ROM_WORDS   = 1024;
    localparam int          RAM_WORDS   = 512;
    localparam logic [31:0] FORBID_ADDR = 32'h0000_0100;
    localparam logic [31:0] LOAD_BASE   = 32'h0000_0200;
    localparam logic [31:0] RESULT_BASE = 32'h0000_0400;
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  we;
        logic [31:0] data;
    } mem_write_t;

    logic        clk;
    logic        reset_i;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] mem_data_i;
    logic [31:0] instruction_address_o;
    logic        mem_operation_enable_o;
    logic [3:0]  mem_write_enable_o;
    logic [31:0] mem_address_o;
    logic [31:0] mem_data_o;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];
    logic [31:0] read_word;
    mem_write_t  expected_q [$];
    mem_write_t  got, want;
    integer      seed = 63;
    int          prog_len, load_idx, stall_left;
    logic [31:0] res_addr;
    int          errors, stores_checked, cycles, limit;
    logic        timed_out;

    `include "tb_program.svh"

    rv32_pipe uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk)
        cycles <= cycles + 1;

    // Instruction ROM answers in the same cycle
    assign instruction_i = rom[instruction_address_o[11:2]];

    ////////////////////////////////////////////////////////////////////////////
    // Data RAM with in-order store checking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (mem_operation_enable_o && mem_write_enable_o != 4'b0000) begin
            got = '{addr: mem_address_o, we: mem_write_enable_o, data: mem_data_o};
            if (expected_q.size() == 0) begin
                errors++;
                $display("Store to %h at time %0t that the program never makes",
                         mem_address_o, $time);
            end
            else begin
                want = expected_q.pop_front();
                stores_checked++;
                assert (got == want) else begin
                    errors++;
                    $display("FAILED at %0t: store %h lanes %b data %h, expected %h %b %h",
                             $time, got.addr, got.we, got.data, want.addr, want.we, want.data);
                end
            end
            for (int i = 0; i < 4; i++)
                if (mem_write_enable_o[i])
                    ram[mem_address_o[10:2]][8*i +: 8] <= mem_data_o[8*i +: 8];
        end
        else if (mem_operation_enable_o) begin
            read_word <= ram[mem_address_o[10:2]];
        end
    end

    // Read data shows up one cycle after the request and is held
    always @(negedge clk)
        mem_data_i = read_word;

    // Random stall pulses of 1 to 3 cycles
    always @(negedge clk) begin
        if (reset_i) begin
            stall_i = 1'b0;
        end
        else begin
            if (stall_left == 0 && $unsigned($random(seed)) % 5 == 0)
                stall_left = 1 + $unsigned($random(seed)) % 3;
            stall_i = (stall_left > 0);
            if (stall_left > 0)
                stall_left--;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Protocol assertions
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) (reset_i && cycles > 0) |-> !mem_operation_enable_o)
    else begin
        errors++;
        $display("FAILED at %0t: memory request during reset", $time);
    end

    assert property (@(posedge clk) $fell(reset_i)
                     |-> (!mem_operation_enable_o && instruction_address_o == `RESET_PC))
    else begin
        errors++;
        $display("FAILED at %0t: first cycle after reset, pc %h", $time,
                 instruction_address_o);
    end

    assert property (@(posedge clk) stall_i |-> !mem_operation_enable_o)
    else begin
        errors++;
        $display("FAILED at %0t: memory request while stalled", $time);
    end

    assert property (@(posedge clk) (mem_operation_enable_o && mem_write_enable_o != 4'b0)
                     |-> mem_address_o != FORBID_ADDR)
    else begin
        errors++;
        $display("FAILED at %0t: store to the skipped address", $time);
    end

    initial begin
        clk        = 1'b0;
        reset_i    = 1'b1;
        stall_i    = 1'b0;
        mem_data_i = '0;
        read_word  = '0;
        errors     = 0;
        cycles     = 0;
        stall_left = 0;
        stores_checked = 0;
        for (int i = 0; i < RAM_WORDS; i++)
            ram[i] = {~i[15:0], i[15:0]} ^ 32'h3C5A_0000;
        build_program();
        limit = 8 * prog_len + 200;

        repeat (2) @(negedge clk);
        reset_i = 1'b0;

        while (expected_q.size() > 0 && cycles < limit)
            @(negedge clk);
        // A few more cycles on the self loop to catch stray stores
        repeat (8) @(negedge clk);

        timed_out = (expected_q.size() > 0);
        if (timed_out)
            $display("Timeout after %0d cycles with %0d stores still missing",
                     cycles, expected_q.size());
        $display("Errors: %0d, stores checked: %0d, cycles: %0d",
                 errors, stores_checked, cycles);
        if (errors == 0 && !timed_out)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: rv32_pipe.f
+incdir+src
+incdir+tests
src/rv32_pkg.sv
src/fetch.sv
src/decode.sv
src/regbank.sv
src/execute.sv
src/retire.sv
src/rv32_pipe.sv
tests/tb_rv32_pipe.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv32_pipe testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f rv32_pipe.f \
    --top-module tb_rv32_pipe

./obj_dir/Vtb_rv32_pipe | tee sim.log

grep -q "^TEST OK$" sim.log
